//--- udp_rx.f
udp_rx_pkg.sv
udp_rx_sync_fifo.sv
udp_rx_header_check.sv
udp_rx_payload_align.sv
udp_rx_frame_queue.sv
udp_rx.sv
udp_rx_tb.sv

//--- udp_rx.sv
`timescale 1ns/100ps

module udp_rx (
  input  logic                            mac_clk,
  input  logic                            mac_rst,
  input  logic                            local_enable,
  input  logic [udp_rx_pkg::MAC_W-1:0]    local_mac,
  input  logic [udp_rx_pkg::IP_W-1:0]     local_ip,
  input  logic [udp_rx_pkg::PORT_W-1:0]   local_port,
  input  logic [udp_rx_pkg::DATA_W-1:0]   mac_rx_data,
  input  logic [udp_rx_pkg::DATA_W/8-1:0] mac_rx_data_valid,
  input  logic                            mac_rx_good_frame,
  input  logic                            mac_rx_bad_frame,
  output logic                            out_valid,
  output logic [udp_rx_pkg::DATA_W-1:0]   out_data,
  output logic                            out_last,
  output logic                            out_bad,
  output logic                            out_overrun,
  output logic [udp_rx_pkg::IP_W-1:0]     out_source_ip,
  output logic [udp_rx_pkg::PORT_W-1:0]   out_source_port,
  input  logic                            out_ready
);

  logic [udp_rx_pkg::DATA_W-1:0] word_data;
  logic                          word_valid;
  logic                          end_good;
  logic                          end_bad;
  logic                          frame_accept;
  logic [udp_rx_pkg::IP_W-1:0]   source_ip;
  logic [udp_rx_pkg::PORT_W-1:0] source_port;
  logic                          pay_valid;
  logic [udp_rx_pkg::DATA_W-1:0] pay_data;
  logic                          pay_last;
  logic                          pay_bad;

  // MAC input register, only full words count
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      word_valid <= 1'b0;
      end_good   <= 1'b0;
      end_bad    <= 1'b0;
    end else begin
      word_valid <= &mac_rx_data_valid;
      end_good   <= mac_rx_good_frame;
      end_bad    <= mac_rx_bad_frame;
    end
  end

  always_ff @(posedge mac_clk) begin
    word_data <= mac_rx_data;
  end

  udp_rx_header_check i_header_check (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .word_data    (word_data),
    .word_valid   (word_valid),
    .end_good     (end_good),
    .end_bad      (end_bad),
    .local_enable (local_enable),
    .local_mac    (local_mac),
    .local_ip     (local_ip),
    .local_port   (local_port),
    .frame_accept (frame_accept),
    .source_ip    (source_ip),
    .source_port  (source_port)
  );

  udp_rx_payload_align i_payload_align (
    .mac_clk    (mac_clk),
    .mac_rst    (mac_rst),
    .word_data  (word_data),
    .word_valid (word_valid),
    .end_good   (end_good),
    .end_bad    (end_bad),
    .pay_valid  (pay_valid),
    .pay_data   (pay_data),
    .pay_last   (pay_last),
    .pay_bad    (pay_bad)
  );

  udp_rx_frame_queue i_frame_queue (
    .mac_clk         (mac_clk),
    .mac_rst         (mac_rst),
    .frame_accept    (frame_accept),
    .source_ip       (source_ip),
    .source_port     (source_port),
    .pay_valid       (pay_valid),
    .pay_data        (pay_data),
    .pay_last        (pay_last),
    .pay_bad         (pay_bad),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .out_last        (out_last),
    .out_bad         (out_bad),
    .out_overrun     (out_overrun),
    .out_source_ip   (out_source_ip),
    .out_source_port (out_source_port)
  );

endmodule

//--- udp_rx_frame_queue.sv
`timescale 1ns/100ps

module udp_rx_frame_queue (
  input  logic                          mac_clk,
  input  logic                          mac_rst,
  input  logic                          frame_accept,
  input  logic [udp_rx_pkg::IP_W-1:0]   source_ip,
  input  logic [udp_rx_pkg::PORT_W-1:0] source_port,
  input  logic                          pay_valid,
  input  logic [udp_rx_pkg::DATA_W-1:0] pay_data,
  input  logic                          pay_last,
  input  logic                          pay_bad,
  input  logic                          out_ready,
  output logic                          out_valid,
  output logic [udp_rx_pkg::DATA_W-1:0] out_data,
  output logic                          out_last,
  output logic                          out_bad,
  output logic                          out_overrun,
  output logic [udp_rx_pkg::IP_W-1:0]   out_source_ip,
  output logic [udp_rx_pkg::PORT_W-1:0] out_source_port
);

  udp_rx_pkg::queue_state_t state;

  logic                                           first_word;
  logic                                           accept_word;
  logic                                           room;
  logic                                           near_full;
  logic                                           wr_last;
  logic                                           pay_wr_en;
  logic                                           meta_wr_en;
  logic                                           pay_rd_en;
  logic                                           meta_rd_en;
  logic [udp_rx_pkg::DATA_W+2:0]                  pay_wr_data;
  logic [udp_rx_pkg::DATA_W+2:0]                  pay_rd_data;
  logic [udp_rx_pkg::IP_W+udp_rx_pkg::PORT_W-1:0] meta_wr_data;
  logic [udp_rx_pkg::IP_W+udp_rx_pkg::PORT_W-1:0] meta_rd_data;
  logic [udp_rx_pkg::DATA_CNT_W-1:0]              pay_count;
  logic [udp_rx_pkg::META_CNT_W-1:0]              meta_count;
  logic                                           pay_not_empty;
  logic                                           meta_not_empty;

  assign accept_word = pay_valid && frame_accept && state == udp_rx_pkg::QUEUE_RUN;

  // Free slots at or below the margin
  assign near_full = pay_count >= udp_rx_pkg::DATA_CNT_W'(
                       udp_rx_pkg::DATA_FIFO_DEPTH - udp_rx_pkg::ALMOST_FULL_MARGIN);

  // A new frame needs a metadata slot, and no word fits a full payload FIFO
  assign room = pay_count != udp_rx_pkg::DATA_CNT_W'(udp_rx_pkg::DATA_FIFO_DEPTH) &&
                !(first_word &&
                  meta_count == udp_rx_pkg::META_CNT_W'(udp_rx_pkg::META_FIFO_DEPTH));

  assign wr_last      = pay_last || near_full;
  assign pay_wr_en    = accept_word && room;
  assign meta_wr_en   = pay_wr_en && first_word;
  assign pay_wr_data  = {near_full, pay_bad, wr_last, pay_data};
  assign meta_wr_data = {source_port, source_ip};

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state      <= udp_rx_pkg::QUEUE_RUN;
      first_word <= 1'b1;
    end else begin
      case (state)
        udp_rx_pkg::QUEUE_RUN: begin
          if (accept_word) begin
            if (!room) begin
              // Whole frame dropped
              if (!pay_last) begin
                state <= udp_rx_pkg::QUEUE_DISCARD;
              end
            end else begin
              first_word <= wr_last;
              if (near_full && !pay_last) begin
                state <= udp_rx_pkg::QUEUE_DISCARD;
              end
            end
          end
        end
        udp_rx_pkg::QUEUE_DISCARD: begin
          if (pay_valid && pay_last) begin
            state <= udp_rx_pkg::QUEUE_RUN;
          end
        end
      endcase
    end
  end

  udp_rx_sync_fifo #(
    .WIDTH (udp_rx_pkg::DATA_W + 3),
    .DEPTH (udp_rx_pkg::DATA_FIFO_DEPTH)
  ) i_data_fifo (
    .mac_clk   (mac_clk),
    .mac_rst   (mac_rst),
    .wr_en     (pay_wr_en),
    .wr_data   (pay_wr_data),
    .rd_en     (pay_rd_en),
    .rd_data   (pay_rd_data),
    .not_empty (pay_not_empty),
    .count     (pay_count)
  );

  udp_rx_sync_fifo #(
    .WIDTH (udp_rx_pkg::IP_W + udp_rx_pkg::PORT_W),
    .DEPTH (udp_rx_pkg::META_FIFO_DEPTH)
  ) i_meta_fifo (
    .mac_clk   (mac_clk),
    .mac_rst   (mac_rst),
    .wr_en     (meta_wr_en),
    .wr_data   (meta_wr_data),
    .rd_en     (meta_rd_en),
    .rd_data   (meta_rd_data),
    .not_empty (meta_not_empty),
    .count     (meta_count)
  );

  // Metadata advances when the last word of a frame transfers
  assign pay_rd_en  = out_valid && out_ready;
  assign meta_rd_en = pay_rd_en && out_last && meta_not_empty;

  assign out_valid = pay_not_empty;
  assign {out_overrun, out_bad, out_last, out_data} = pay_rd_data;
  assign {out_source_port, out_source_ip}           = meta_rd_data;

endmodule

//--- udp_rx_header_check.sv
`timescale 1ns/100ps

module udp_rx_header_check (
  input  logic                          mac_clk,
  input  logic                          mac_rst,
  input  logic [udp_rx_pkg::DATA_W-1:0] word_data,
  input  logic                          word_valid,
  input  logic                          end_good,
  input  logic                          end_bad,
  input  logic                          local_enable,
  input  logic [udp_rx_pkg::MAC_W-1:0]  local_mac,
  input  logic [udp_rx_pkg::IP_W-1:0]   local_ip,
  input  logic [udp_rx_pkg::PORT_W-1:0] local_port,
  output logic                          frame_accept,
  output logic [udp_rx_pkg::IP_W-1:0]   source_ip,
  output logic [udp_rx_pkg::PORT_W-1:0] source_port
);

  udp_rx_pkg::hdr_state_t state;

  logic [udp_rx_pkg::MAC_W-1:0]  dest_mac;
  logic [15:0]                   ethertype;
  logic [7:0]                    ver_ihl;
  logic [7:0]                    protocol;
  logic [udp_rx_pkg::IP_W-1:0]   word_source_ip;
  logic [15:0]                   dest_ip_hi;
  logic [udp_rx_pkg::IP_W-1:0]   dest_ip;
  logic [udp_rx_pkg::PORT_W-1:0] word_source_port;
  logic [udp_rx_pkg::PORT_W-1:0] dest_port;
  logic                          frame_end;

  // Byte 0 arrives first and is the most significant byte of a field
  assign dest_mac = {word_data[7:0],   word_data[15:8],  word_data[23:16],
                     word_data[31:24], word_data[39:32], word_data[47:40]};

  // Word 2 fields
  assign ethertype = {word_data[39:32], word_data[47:40]};
  assign ver_ihl   = word_data[55:48];

  // Word 3 field
  assign protocol = word_data[63:56];

  // Word 4 fields
  assign word_source_ip = {word_data[23:16], word_data[31:24],
                           word_data[39:32], word_data[47:40]};

  // Word 5 fields, upper half of the destination IP came in word 4
  assign dest_ip          = {dest_ip_hi, word_data[7:0], word_data[15:8]};
  assign word_source_port = {word_data[23:16], word_data[31:24]};
  assign dest_port        = {word_data[39:32], word_data[47:40]};

  assign frame_end = end_good || end_bad;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state        <= udp_rx_pkg::HDR_IDLE;
      frame_accept <= 1'b0;
    end else begin
      case (state)
        udp_rx_pkg::HDR_IDLE: begin
          if (word_valid) begin
            if (dest_mac == local_mac || dest_mac == udp_rx_pkg::BROADCAST_MAC) begin
              frame_accept <= 1'b1;
              state        <= udp_rx_pkg::HDR_WORD2;
            end else begin
              frame_accept <= 1'b0;
              state        <= udp_rx_pkg::HDR_SKIP;
            end
          end
        end
        udp_rx_pkg::HDR_WORD2: begin
          if (word_valid) begin
            if (ethertype != udp_rx_pkg::ETHERTYPE_IPV4 || ver_ihl != udp_rx_pkg::IP_VER_IHL) begin
              frame_accept <= 1'b0;
              state        <= udp_rx_pkg::HDR_SKIP;
            end else begin
              state <= udp_rx_pkg::HDR_WORD3;
            end
          end
        end
        udp_rx_pkg::HDR_WORD3: begin
          if (word_valid) begin
            if (protocol != udp_rx_pkg::IP_PROTO_UDP) begin
              frame_accept <= 1'b0;
              state        <= udp_rx_pkg::HDR_SKIP;
            end else begin
              state <= udp_rx_pkg::HDR_WORD4;
            end
          end
        end
        udp_rx_pkg::HDR_WORD4: begin
          if (word_valid) begin
            state <= udp_rx_pkg::HDR_WORD5;
          end
        end
        udp_rx_pkg::HDR_WORD5: begin
          // Final decision for this frame
          if (word_valid) begin
            if (dest_ip != local_ip || dest_port != local_port) begin
              frame_accept <= 1'b0;
              state        <= udp_rx_pkg::HDR_SKIP;
            end else begin
              state <= udp_rx_pkg::HDR_WORD6;
            end
          end
        end
        udp_rx_pkg::HDR_WORD6: begin
          if (word_valid) begin
            state <= udp_rx_pkg::HDR_PAYLOAD;
          end
        end
        default: begin
          // Payload or skipped frame, wait for the end strobe
        end
      endcase
      if (frame_end) begin
        state <= udp_rx_pkg::HDR_IDLE;
      end
      if (!local_enable) begin
        frame_accept <= 1'b0;
      end
    end
  end

  // Source address capture
  always_ff @(posedge mac_clk) begin
    if (word_valid && state == udp_rx_pkg::HDR_WORD4) begin
      source_ip  <= word_source_ip;
      dest_ip_hi <= {word_data[55:48], word_data[63:56]};
    end
    if (word_valid && state == udp_rx_pkg::HDR_WORD5) begin
      source_port <= word_source_port;
    end
  end

endmodule

//--- udp_rx_payload_align.sv
`timescale 1ns/100ps

module udp_rx_payload_align (
  input  logic                          mac_clk,
  input  logic                          mac_rst,
  input  logic [udp_rx_pkg::DATA_W-1:0] word_data,
  input  logic                          word_valid,
  input  logic                          end_good,
  input  logic                          end_bad,
  output logic                          pay_valid,
  output logic [udp_rx_pkg::DATA_W-1:0] pay_data,
  output logic                          pay_last,
  output logic                          pay_bad
);

  // Words seen so far in this frame, saturates at seven
  logic [2:0]                    word_cnt;
  logic [udp_rx_pkg::DATA_W-1:0] prev_data;
  logic [udp_rx_pkg::DATA_W-1:0] held_data;
  logic                          held_valid;
  logic [udp_rx_pkg::DATA_W-1:0] shifted;
  logic                          form_word;
  logic                          frame_end;

  assign frame_end = end_good || end_bad;

  // Word 7 onward completes a payload word
  assign form_word = word_valid && word_cnt >= 3'd6;

  // Bytes 2 to 7 of the previous word, then bytes 0 and 1 of this one
  assign shifted = {word_data[15:0], prev_data[udp_rx_pkg::DATA_W-1:16]};

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      word_cnt   <= 3'd0;
      held_valid <= 1'b0;
      pay_valid  <= 1'b0;
    end else begin
      pay_valid <= 1'b0;
      if (frame_end) begin
        // Held word is the last one of the frame
        word_cnt   <= 3'd0;
        held_valid <= 1'b0;
        pay_valid  <= held_valid;
      end else if (word_valid) begin
        if (word_cnt != 3'd7) begin
          word_cnt <= word_cnt + 3'd1;
        end
        if (form_word) begin
          held_valid <= 1'b1;
          pay_valid  <= held_valid;
        end
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (word_valid) begin
      prev_data <= word_data;
    end
    if (frame_end) begin
      pay_data <= held_data;
      pay_last <= 1'b1;
      pay_bad  <= end_bad;
    end else if (form_word) begin
      pay_data  <= held_data;
      pay_last  <= 1'b0;
      pay_bad   <= 1'b0;
      held_data <= shifted;
    end
  end

endmodule

//--- udp_rx_pkg.sv
package udp_rx_pkg;

  // Datapath and address field widths
  localparam int DATA_W = 64;
  localparam int MAC_W  = 48;
  localparam int IP_W   = 32;
  localparam int PORT_W = 16;

  // Protocol constants, network order
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  // Version 4, five-word header with no options
  localparam logic [7:0] IP_VER_IHL = 8'h45;

  localparam logic [7:0] IP_PROTO_UDP = 8'h11;

  localparam logic [MAC_W-1:0] BROADCAST_MAC = {MAC_W{1'b1}};

  // Buffer sizes
  localparam int DATA_FIFO_DEPTH = 16;
  localparam int META_FIFO_DEPTH = 4;

  // Free payload slots at or below this mark a write as overrun
  localparam int ALMOST_FULL_MARGIN = 2;

  // Occupancy count widths of the two FIFOs
  localparam int DATA_CNT_W = $clog2(DATA_FIFO_DEPTH + 1);
  localparam int META_CNT_W = $clog2(META_FIFO_DEPTH + 1);

  // Header checker states, one per header word
  typedef enum logic [2:0] {
    HDR_IDLE,
    HDR_WORD2,
    HDR_WORD3,
    HDR_WORD4,
    HDR_WORD5,
    HDR_WORD6,
    HDR_PAYLOAD,
    HDR_SKIP
  } hdr_state_t;

  // Frame queue states
  typedef enum logic {
    QUEUE_RUN,
    QUEUE_DISCARD
  } queue_state_t;

endpackage

//--- udp_rx_sync_fifo.sv
`timescale 1ns/100ps

module udp_rx_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                         mac_clk,
  input  logic                         mac_rst,
  input  logic                         wr_en,
  input  logic [WIDTH-1:0]             wr_data,
  input  logic                         rd_en,
  output logic [WIDTH-1:0]             rd_data,
  output logic                         not_empty,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  // Writes into a full FIFO are dropped
  assign do_wr = wr_en && count != CNT_W'(DEPTH);
  assign do_rd = rd_en && not_empty;

  // First word fall-through
  assign rd_data   = mem[rd_ptr];
  assign not_empty = count != '0;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

//--- udp_rx_tb.sv
`timescale 1ns/100ps

module udp_rx_tb;

  localparam int NUM_ROWS  = 16;
  localparam int MAX_WORDS = 32;

  // Output ready patterns per table row
  localparam logic [1:0] READY_ON     = 2'd0;
  localparam logic [1:0] READY_RANDOM = 2'd1;
  localparam logic [1:0] READY_HOLD   = 2'd2;

  localparam logic [47:0] LOCAL_MAC  = 48'h02005e102030;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a80a05;
  localparam logic [15:0] LOCAL_PORT = 16'h1389;

  typedef struct packed {
    logic [47:0] dest_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  protocol;
    logic [31:0] dest_ip;
    logic [15:0] dest_port;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [7:0]  words;
    logic        bad;
    logic        enable;
    logic [1:0]  ready_mode;
    logic        accept;
  } frame_row_t;

  logic        mac_clk = 1'b0;
  logic        mac_rst;
  logic        local_enable;
  logic [47:0] local_mac;
  logic [31:0] local_ip;
  logic [15:0] local_port;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        out_valid;
  logic [63:0] out_data;
  logic        out_last;
  logic        out_bad;
  logic        out_overrun;
  logic [31:0] out_source_ip;
  logic [15:0] out_source_port;
  logic        out_ready;

  frame_row_t  rows [NUM_ROWS];
  logic [63:0] words [1:MAX_WORDS];
  logic [1:0]  ready_mode;
  int          seed_value;

  // Scoreboard, flags are {overrun, bad, last}
  logic [63:0] exp_data [$];
  logic [2:0]  exp_flags [$];
  logic [31:0] exp_ip [$];
  logic [15:0] exp_port [$];

  always #10 mac_clk = ~mac_clk;

  udp_rx i_udp_rx (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .out_valid         (out_valid),
    .out_data          (out_data),
    .out_last          (out_last),
    .out_bad           (out_bad),
    .out_overrun       (out_overrun),
    .out_source_ip     (out_source_ip),
    .out_source_port   (out_source_port),
    .out_ready         (out_ready)
  );

  // Matching frame that is always accepted
  function automatic frame_row_t good_row(input logic [7:0] n, input logic [31:0] sip,
                                          input logic [15:0] sport);
    frame_row_t r;
    r.dest_mac   = LOCAL_MAC;
    r.ethertype  = 16'h0800;
    r.ver_ihl    = 8'h45;
    r.protocol   = 8'h11;
    r.dest_ip    = LOCAL_IP;
    r.dest_port  = LOCAL_PORT;
    r.src_ip     = sip;
    r.src_port   = sport;
    r.words      = n;
    r.bad        = 1'b0;
    r.enable     = 1'b1;
    r.ready_mode = READY_ON;
    r.accept     = 1'b1;
    return r;
  endfunction

  task automatic fill_table();
    frame_row_t r;
    rows[0] = good_row(8'd10, 32'h0a000001, 16'h1234);
    r = good_row(8'd8, 32'h0a000002, 16'h2345);
    r.dest_mac = 48'hffffffffffff;
    rows[1] = r;
    // Rejected frames, one wrong field each
    r = good_row(8'd10, 32'h0a000003, 16'h3456);
    r.dest_mac = 48'h02005e102031;
    r.accept = 1'b0;
    rows[2] = r;
    r.dest_mac = LOCAL_MAC;
    r.ethertype = 16'h86dd;
    rows[3] = r;
    r.ethertype = 16'h0800;
    r.ver_ihl = 8'h46;
    rows[4] = r;
    r.ver_ihl = 8'h45;
    r.protocol = 8'h06;
    rows[5] = r;
    r.protocol = 8'h11;
    r.dest_ip = 32'hc0a80a06;
    rows[6] = r;
    r.dest_ip = LOCAL_IP;
    r.dest_port = 16'h1388;
    rows[7] = r;
    r.dest_port = LOCAL_PORT;
    r.enable = 1'b0;
    rows[8] = r;
    r = good_row(8'd9, 32'h0a000004, 16'h4567);
    r.bad = 1'b1;
    rows[9] = r;
    // Back-to-back frames with random out_ready
    r = good_row(8'd7, 32'h0a000005, 16'h5678);
    r.ready_mode = READY_RANDOM;
    rows[10] = r;
    r.words = 8'd12;
    r.src_ip = 32'h0a000006;
    r.src_port = 16'h6789;
    rows[11] = r;
    r.words = 8'd9;
    r.dest_port = 16'h0035;
    r.accept = 1'b0;
    rows[12] = r;
    r.words = 8'd14;
    r.dest_port = LOCAL_PORT;
    r.src_ip = 32'h0a000007;
    r.src_port = 16'h789a;
    r.accept = 1'b1;
    rows[13] = r;
    // Long frame into a stalled output
    r = good_row(8'd30, 32'h0a000008, 16'h89ab);
    r.ready_mode = READY_HOLD;
    rows[14] = r;
    rows[15] = good_row(8'd11, 32'h0a000009, 16'h9abc);
  endtask

  // Field bytes go out most significant first, starting at byte first
  task automatic put_field(input int w, input int first, input int nbytes,
                           input logic [47:0] value);
    int j;
    for (j = 0; j < nbytes; j++) begin
      words[w][8*(first+j) +: 8] = value[8*(nbytes-1-j) +: 8];
    end
  endtask

  task automatic build_frame(input frame_row_t r);
    int i;
    for (i = 1; i <= r.words; i++) begin
      words[i] = {$urandom, $urandom};
    end
    put_field(1, 0, 6, r.dest_mac);
    put_field(2, 4, 2, r.ethertype);
    put_field(2, 6, 1, r.ver_ihl);
    put_field(3, 7, 1, r.protocol);
    put_field(4, 2, 4, r.src_ip);
    put_field(4, 6, 2, r.dest_ip[31:16]);
    put_field(5, 0, 2, r.dest_ip[15:0]);
    put_field(5, 2, 2, r.src_port);
    put_field(5, 4, 2, r.dest_port);
  endtask

  // Output word k takes bytes 2 to 7 of word 6+k, then bytes 0 and 1 of word 7+k
  task automatic push_expected(input frame_row_t r);
    int n;
    int k;
    int b;
    int limit;
    logic [63:0] w;
    logic last;
    logic overrun;
    n = r.words;
    limit = MAX_WORDS;
    // Drained FIFO, so write k sees DEPTH-k free slots
    if (r.ready_mode == READY_HOLD) begin
      limit = udp_rx_pkg::DATA_FIFO_DEPTH - udp_rx_pkg::ALMOST_FULL_MARGIN;
    end
    for (k = 0; k <= n - 7; k++) begin
      for (b = 0; b < 8; b++) begin
        if (b < 6) begin
          w[8*b +: 8] = words[6+k][8*(b+2) +: 8];
        end else begin
          w[8*b +: 8] = words[7+k][8*(b-6) +: 8];
        end
      end
      overrun = (k == limit);
      last = (k == n - 7) || overrun;
      exp_data.push_back(w);
      exp_flags.push_back({overrun, r.bad && (k == n - 7), last});
      exp_ip.push_back(r.src_ip);
      exp_port.push_back(r.src_port);
      if (overrun) begin
        break;
      end
    end
  endtask

  task automatic drive_cycle(input logic [63:0] data, input logic [7:0] mask,
                             input logic good, input logic bad);
    @(negedge mac_clk);
    mac_rx_data       = data;
    mac_rx_data_valid = mask;
    mac_rx_good_frame = good;
    mac_rx_bad_frame  = bad;
    case (ready_mode)
      READY_ON:     out_ready = 1'b1;
      READY_RANDOM: out_ready = ($urandom % 4) != 0;
      default:      out_ready = 1'b0;
    endcase
  endtask

  task automatic idle_cycle();
    drive_cycle({$urandom, $urandom}, 8'h00, 1'b0, 1'b0);
  endtask

  task automatic drive_frame(input frame_row_t r);
    int i;
    for (i = 1; i <= r.words; i++) begin
      drive_cycle(words[i], 8'hff, 1'b0, 1'b0);
    end
    // End strobe one cycle after the last word
    drive_cycle({$urandom, $urandom}, 8'h00, !r.bad, r.bad);
    repeat (5) idle_cycle();
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_output();
    logic [63:0] data;
    logic [2:0]  flags;
    logic [31:0] ip;
    logic [15:0] port;
    if (exp_data.size() == 0) begin
      $display("Output word at %0t ns arrived when no word was expected", $time);
      $display("Simulation failed");
      $fatal(1);
    end else begin
      data  = exp_data.pop_front();
      flags = exp_flags.pop_front();
      ip    = exp_ip.pop_front();
      port  = exp_port.pop_front();
      check_value("out_data", out_data, data);
      check_value("out_last", out_last, flags[0]);
      check_value("out_bad", out_bad, flags[1]);
      check_value("out_overrun", out_overrun, flags[2]);
      check_value("out_source_ip", out_source_ip, ip);
      check_value("out_source_port", out_source_port, port);
    end
  endtask

  // Output monitor
  always @(posedge mac_clk) begin
    if (!mac_rst && out_valid && out_ready) begin
      check_output();
    end
  end

  initial begin
    repeat (NUM_ROWS * 200) @(posedge mac_clk);
    $display("Timeout: test did not finish within %0d clock cycles", NUM_ROWS * 200);
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    seed_value        = $urandom(32'hc77df66a);
    mac_rst           = 1'b1;
    local_enable      = 1'b1;
    local_mac         = LOCAL_MAC;
    local_ip          = LOCAL_IP;
    local_port        = LOCAL_PORT;
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    out_ready         = 1'b0;
    ready_mode        = READY_ON;
    fill_table();
    repeat (2) @(posedge mac_clk);
    @(negedge mac_clk);
    mac_rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].ready_mode == READY_HOLD) begin
        // Empty the output path before stalling it
        ready_mode = READY_ON;
        while (exp_data.size() != 0) begin
          idle_cycle();
        end
        ready_mode = READY_HOLD;
      end else begin
        ready_mode = rows[i].ready_mode;
      end
      local_enable = rows[i].enable;
      build_frame(rows[i]);
      if (rows[i].accept) begin
        push_expected(rows[i]);
      end
      drive_frame(rows[i]);
      if (rows[i].ready_mode == READY_HOLD) begin
        ready_mode = READY_ON;
      end
    end

    ready_mode = READY_ON;
    // Bounded drain, missing words stay in the scoreboard
    for (int c = 0; c < 100 && exp_data.size() != 0; c++) begin
      idle_cycle();
    end
    // Catch any stray words after the last frame
    repeat (10) idle_cycle();

    if (exp_data.size() != 0) begin
      $display("Scoreboard still holds %0d words at the end of the run", exp_data.size());
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule
